// File: rv_core_top.f
+incdir+src
src/rv_isa_pkg.sv
src/rv_core_pkg.sv
src/if_stage.sv
src/id_stage.sv
src/regfile.sv
src/exe_stage.sv
src/mem_stage.sv
src/rv_core_top.sv
tb/tb_clock_gen.sv
tb/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it; exit status follows the test result.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module rv_core_tb \
  -f rv_core_top.f \
  --Mdir obj_dir -o rv_core_sim

./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if ! grep -q "No errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

// File: tb/rv_core_tb.sv
// program testbench for the core: answers fetches from a table and checks each commit record
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_core_tb;
  import rv_core_pkg::*;

  typedef struct packed {
    logic [31:0]      inst;
    logic [`XLEN-1:0] pc;
    logic             wen;
    logic [4:0]       wdest;
    logic [`XLEN-1:0] wdata;
  } row_t;

  localparam int N_ROWS      = 30;
  localparam int CYCLE_LIMIT = 16 + N_ROWS * 4 + 20;

  logic             clock;
  logic             reset;
  logic [31:0]      inst;
  logic             inst_valid;
  logic [`XLEN-1:0] fetch_pc;
  logic             inst_ready;
  commit_t          commit;
  row_t             rows [N_ROWS];
  int               row_count = 0;
  int               errors = 0;
  int               cycles = 0;
  int               idle;
  integer           seed = 3;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(16)) clock_gen_i (.clock(clock), .reset(reset));

  rv_core_top UUT (
    .clock(clock), .reset(reset), .inst(inst), .inst_valid(inst_valid),
    .fetch_pc(fetch_pc), .inst_ready(inst_ready), .commit(commit)
  );

  // standard RV32 base formats
  function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3,
                                         input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] funct3, input logic [4:0] rd,
                                         input logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3);
    return {imm[11:5], rs2, rs1, funct3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_row(input logic [31:0] word, input logic [11:0] pc_offset,
                         input logic wen, input logic [4:0] wdest,
                         input logic [`XLEN-1:0] wdata);
    rows[row_count] = {word, `PC_START + {52'b0, pc_offset}, wen, wdest, wdata};
    row_count++;
  endtask

  // x1 = 5 and x2 = -3 feed most of the ALU rows
  task automatic build_program;
    add_row(i_type(12'd5, 5'd0, 3'b000, 5'd1, 7'h13), 12'h00, 1'b1, 5'd1, 64'd5);
    add_row(i_type(12'hffd, 5'd0, 3'b000, 5'd2, 7'h13), 12'h04, 1'b1, 5'd2,
            64'hffff_ffff_ffff_fffd);
    add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 12'h08, 1'b1, 5'd3, 64'd2);
    add_row(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 12'h0c, 1'b1, 5'd4, 64'd8);
    add_row(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 12'h10, 1'b1, 5'd5, 64'd5);
    add_row(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 12'h14, 1'b1, 5'd6,
            64'hffff_ffff_ffff_fffd);
    add_row(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 12'h18, 1'b1, 5'd7,
            64'hffff_ffff_ffff_fff8);
    add_row(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 12'h1c, 1'b1, 5'd8, 64'd1);
    add_row(r_type(7'h00, 5'd1, 5'd1, 3'b001, 5'd9), 12'h20, 1'b1, 5'd9, 64'h0a0);
    add_row(r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd10), 12'h24, 1'b1, 5'd10,
            64'h07ff_ffff_ffff_ffff);
    add_row(u_type(20'h12345, 5'd11), 12'h28, 1'b1, 5'd11, 64'h1234_5000);
    add_row(u_type(20'hfffff, 5'd12), 12'h2c, 1'b1, 5'd12, 64'hffff_ffff_ffff_f000);
    // write to x0 is dropped, the next row reads x0 back
    add_row(i_type(12'd7, 5'd1, 3'b000, 5'd0, 7'h13), 12'h30, 1'b0, 5'd0, 64'd0);
    add_row(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd13), 12'h34, 1'b1, 5'd13, 64'd5);
    add_row(s_type(12'd16, 5'd2, 5'd0, 3'b011), 12'h38, 1'b0, 5'd0, 64'd0);
    add_row(i_type(12'd16, 5'd0, 3'b011, 5'd14, 7'h03), 12'h3c, 1'b1, 5'd14,
            64'hffff_ffff_ffff_fffd);
    add_row(s_type(12'd32, 5'd12, 5'd0, 3'b010), 12'h40, 1'b0, 5'd0, 64'd0);
    add_row(i_type(12'd32, 5'd0, 3'b010, 5'd15, 7'h03), 12'h44, 1'b1, 5'd15,
            64'hffff_ffff_ffff_f000);
    // upper half of the word stays clear after SW
    add_row(i_type(12'd32, 5'd0, 3'b011, 5'd20, 7'h03), 12'h48, 1'b1, 5'd20,
            64'h0000_0000_ffff_f000);
    // byte 3 of the word at 40
    add_row(s_type(12'd43, 5'd2, 5'd0, 3'b000), 12'h4c, 1'b0, 5'd0, 64'd0);
    add_row(i_type(12'd43, 5'd0, 3'b100, 5'd16, 7'h03), 12'h50, 1'b1, 5'd16, 64'h0fd);
    // whole word shows the byte in lane 3 only
    add_row(i_type(12'd40, 5'd0, 3'b011, 5'd21, 7'h03), 12'h54, 1'b1, 5'd21,
            64'h0000_0000_fd00_0000);
    add_row(b_type(13'd8, 5'd13, 5'd1, 3'b000), 12'h58, 1'b0, 5'd0, 64'd0);
    add_row(b_type(13'd8, 5'd13, 5'd1, 3'b001), 12'h60, 1'b0, 5'd0, 64'd0);
    add_row(b_type(13'd8, 5'd2, 5'd1, 3'b000), 12'h64, 1'b0, 5'd0, 64'd0);
    add_row(b_type(13'd12, 5'd2, 5'd1, 3'b001), 12'h68, 1'b0, 5'd0, 64'd0);
    add_row(j_type(21'd8, 5'd17), 12'h74, 1'b1, 5'd17, 64'h8000_0078);
    // odd target, bit 0 must be cleared
    add_row(i_type(12'd17, 5'd17, 3'b000, 5'd18, 7'h67), 12'h7c, 1'b1, 5'd18,
            64'h8000_0080);
    add_row(32'h0000_0073, 12'h88, 1'b0, 5'd0, 64'd0);
    add_row(i_type(12'd1, 5'd0, 3'b000, 5'd19, 7'h13), 12'h8c, 1'b1, 5'd19, 64'd1);
  endtask

  task automatic check_commit(input int r);
    if (commit.valid !== 1'b1) begin
      $display("no commit record appeared after row %0d was accepted", r);
      errors++;
    end else begin
      if (commit.pc !== rows[r].pc) begin
        $display("Error: commit.pc row %0d got %h expected %h", r, commit.pc, rows[r].pc);
        errors++;
      end
      if (commit.inst !== rows[r].inst) begin
        $display("Error: commit.inst row %0d got %h expected %h", r, commit.inst,
                 rows[r].inst);
        errors++;
      end
      if (commit.wen !== rows[r].wen) begin
        $display("Error: commit.wen row %0d got %h expected %h", r, commit.wen, rows[r].wen);
        errors++;
      end
      if (rows[r].wen && (commit.wdest !== rows[r].wdest)) begin
        $display("Error: commit.wdest row %0d got %h expected %h", r, commit.wdest,
                 rows[r].wdest);
        errors++;
      end
      if (commit.wdata !== rows[r].wdata) begin
        $display("Error: commit.wdata row %0d got %h expected %h", r, commit.wdata,
                 rows[r].wdata);
        errors++;
      end
    end
  endtask

  always @(posedge clock) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles before the program finished", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    inst       = '0;
    inst_valid = 1'b0;
    build_program();

    @(negedge clock);
    while (reset) begin
      if (inst_ready !== 1'b0) begin
        $display("Error: inst_ready during reset got %h expected 0", inst_ready);
        errors++;
      end
      if (commit.valid !== 1'b0) begin
        $display("Error: commit.valid during reset got %h expected 0", commit.valid);
        errors++;
      end
      @(negedge clock);
    end
    if (fetch_pc !== `PC_START) begin
      $display("Error: fetch_pc after reset got %h expected %h", fetch_pc, `PC_START);
      errors++;
    end
    while (!inst_ready) @(negedge clock);

    for (int i = 0; i < N_ROWS; i++) begin
      if (fetch_pc !== rows[i].pc) begin
        $display("Error: fetch_pc row %0d got %h expected %h", i, fetch_pc, rows[i].pc);
        errors++;
      end
      idle = $unsigned($random(seed)) % 3;
      inst = rows[i].inst;
      if (idle > 0) begin
        inst_valid = 1'b0;
        repeat (idle) begin
          @(negedge clock);
          if (commit.valid !== 1'b0) begin
            $display("Error: commit.valid while idle got %h expected 0", commit.valid);
            errors++;
          end
          if (fetch_pc !== rows[i].pc) begin
            $display("Error: fetch_pc while idle got %h expected %h", fetch_pc, rows[i].pc);
            errors++;
          end
        end
      end
      inst_valid = 1'b1;
      @(negedge clock);
      check_commit(i);
    end

    inst_valid = 1'b0;
    @(negedge clock);
    if (commit.valid !== 1'b0) begin
      $display("Error: commit.valid after last row got %h expected 0", commit.valid);
      errors++;
    end

    $display("errors: %0d over %0d program rows", errors, N_ROWS);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// clock and synchronous reset source for the core testbench, instantiated by the top testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  // release on a falling edge so the first sampling edge sees a settled reset
  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: src/rv_core_top.sv
// single-cycle RV64I core top, fetch port in and one registered commit record per retirement
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_core_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [31:0]          inst,
  input  logic                 inst_valid,
  output logic [`XLEN-1:0]     fetch_pc,
  output logic                 inst_ready,
  output rv_core_pkg::commit_t commit
);
  import rv_core_pkg::*;

  decode_ctrl_t     ctrl;
  logic [4:0]       rs1_addr;
  logic [4:0]       rs2_addr;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] rd_wdata;
  logic             take_branch;
  logic             accept;

  assign accept = inst_valid && inst_ready;

  if_stage if_stage_i (
    .clock(clock), .reset(reset), .inst_valid(inst_valid), .ctrl(ctrl),
    .take_branch(take_branch), .rs1_data(rs1_data),
    .fetch_pc(fetch_pc), .inst_ready(inst_ready), .pc_plus4(pc_plus4)
  );

  id_stage id_stage_i (
    .inst(inst), .pc(fetch_pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .ctrl(ctrl)
  );

  regfile regfile_i (
    .clock(clock), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .w_addr(ctrl.rd_addr), .w_data(rd_wdata), .w_ena(accept && ctrl.rd_wen),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  exe_stage exe_stage_i (
    .ctrl(ctrl), .alu_result(alu_result), .take_branch(take_branch)
  );

  mem_stage mem_stage_i (
    .clock(clock), .reset(reset), .accept(accept), .ctrl(ctrl),
    .alu_result(alu_result), .rs2_data(rs2_data), .pc_plus4(pc_plus4),
    .rd_wdata(rd_wdata)
  );

  // record visible the cycle after the accepting edge
  always_ff @(posedge clock) begin
    if (reset) begin
      commit <= '0;
    end else begin
      commit.valid <= accept;
      if (accept) begin
        commit.pc    <= fetch_pc;
        commit.inst  <= inst;
        commit.wen   <= ctrl.rd_wen;
        commit.wdest <= ctrl.rd_addr;
        commit.wdata <= ctrl.rd_wen ? rd_wdata : '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/mem_stage.sv
// data RAM with byte-lane stores, load extraction and write-back select
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module mem_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      accept,
  input  rv_core_pkg::decode_ctrl_t ctrl,
  input  logic [`XLEN-1:0]          alu_result,
  input  logic [`XLEN-1:0]          rs2_data,
  input  logic [`XLEN-1:0]          pc_plus4,
  output logic [`XLEN-1:0]          rd_wdata
);
  import rv_isa_pkg::*;

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  logic [`XLEN-1:0] ram [`DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [2:0]       offset;
  logic [7:0]       size_en;
  logic [7:0]       byte_en;
  logic [`XLEN-1:0] store_data;
  logic [`XLEN-1:0] word_shifted;
  logic [`XLEN-1:0] load_data;

  assign idx    = alu_result[3 +: IDX_W];
  assign offset = alu_result[2:0];

  always_comb begin
    case (ctrl.mem_size)
      MEM_BYTE: size_en = 8'h01;
      MEM_WORD: size_en = 8'h0f;
      default:  size_en = 8'hff;
    endcase
  end

  // lanes move up with the byte offset
  assign byte_en    = size_en << offset;
  assign store_data = rs2_data << {offset, 3'b000};

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        ram[i] <= '0;
      end
    end else if (accept && ctrl.mem_write) begin
      for (int b = 0; b < 8; b++) begin
        if (byte_en[b]) begin
          ram[idx][b*8 +: 8] <= store_data[b*8 +: 8];
        end
      end
    end
  end

  assign word_shifted = ram[idx] >> {offset, 3'b000};

  always_comb begin
    case (ctrl.mem_size)
      MEM_BYTE: load_data = ctrl.mem_unsigned ? {56'b0, word_shifted[7:0]}
                                              : {{56{word_shifted[7]}}, word_shifted[7:0]};
      MEM_WORD: load_data = ctrl.mem_unsigned ? {32'b0, word_shifted[31:0]}
                                              : {{32{word_shifted[31]}}, word_shifted[31:0]};
      default:  load_data = word_shifted;
    endcase
  end

  assign rd_wdata = ctrl.link ? pc_plus4 : (ctrl.mem_read ? load_data : alu_result);

endmodule

`default_nettype wire

// File: src/exe_stage.sv
// ALU and branch-condition evaluation on the decoded operands
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module exe_stage (
  input  rv_core_pkg::decode_ctrl_t ctrl,
  output logic [`XLEN-1:0]          alu_result,
  output logic                      take_branch
);
  import rv_isa_pkg::*;

  logic [5:0] shamt;
  logic       less;
  logic       equal;

  assign shamt = ctrl.op2[5:0];
  assign less  = $signed(ctrl.op1) < $signed(ctrl.op2);
  assign equal = ctrl.op1 == ctrl.op2;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    alu_result = ctrl.op1 + ctrl.op2;
      ALU_SUB:    alu_result = ctrl.op1 - ctrl.op2;
      ALU_AND:    alu_result = ctrl.op1 & ctrl.op2;
      ALU_OR:     alu_result = ctrl.op1 | ctrl.op2;
      ALU_XOR:    alu_result = ctrl.op1 ^ ctrl.op2;
      ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, less};
      ALU_SLL:    alu_result = ctrl.op1 << shamt;
      ALU_SRL:    alu_result = ctrl.op1 >> shamt;
      ALU_PASS_B: alu_result = ctrl.op2;
      ALU_EQ:     alu_result = {{(`XLEN-1){1'b0}}, equal};
      ALU_NE:     alu_result = {{(`XLEN-1){1'b0}}, !equal};
      default:    alu_result = '0;
    endcase
  end

  // compare lands in bit 0 for EQ/NE
  assign take_branch = ctrl.branch && alu_result[0];

endmodule

`default_nettype wire

// File: src/regfile.sv
// integer register file, two combinational reads and one write on the accepting edge
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module regfile (
  input  logic             clock,
  input  logic             reset,
  input  logic [4:0]       rs1_addr,
  input  logic [4:0]       rs2_addr,
  input  logic [4:0]       w_addr,
  input  logic [`XLEN-1:0] w_data,
  input  logic             w_ena,
  output logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] rs2_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (w_ena && (w_addr != 5'd0)) begin
      regs[w_addr] <= w_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: src/id_stage.sv
// instruction decoder producing register addresses, operands, immediates and control
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module id_stage (
  input  logic [31:0]               inst,
  input  logic [`XLEN-1:0]          pc,
  input  logic [`XLEN-1:0]          rs1_data,
  input  logic [`XLEN-1:0]          rs2_data,
  output logic [4:0]                rs1_addr,
  output logic [4:0]                rs2_addr,
  output rv_core_pkg::decode_ctrl_t ctrl
);
  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic             writes;

  assign opcode   = opcode_e'(inst[6:0]);
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl              = '0;
    ctrl.alu_op       = ALU_ADD;
    ctrl.op1          = rs1_data;
    ctrl.op2          = rs2_data;
    ctrl.rd_addr      = inst[11:7];
    ctrl.mem_size     = MEM_DOUBLE;
    ctrl.jump_kind    = JUMP_NONE;
    writes            = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        // only ADDI
        if (funct3 == 3'b000) begin
          ctrl.op2 = imm_i;
          ctrl.imm = imm_i;
          writes   = 1'b1;
        end
      end
      OPC_OP: begin
        writes = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl.alu_op = ALU_ADD;
          10'b0100000_000: ctrl.alu_op = ALU_SUB;
          10'b0000000_111: ctrl.alu_op = ALU_AND;
          10'b0000000_110: ctrl.alu_op = ALU_OR;
          10'b0000000_100: ctrl.alu_op = ALU_XOR;
          10'b0000000_010: ctrl.alu_op = ALU_SLT;
          10'b0000000_001: ctrl.alu_op = ALU_SLL;
          10'b0000000_101: ctrl.alu_op = ALU_SRL;
          default:         writes      = 1'b0;
        endcase
      end
      OPC_LUI: begin
        ctrl.alu_op = ALU_PASS_B;
        ctrl.op2    = imm_u;
        ctrl.imm    = imm_u;
        writes      = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.op2 = imm_i;
        ctrl.imm = imm_i;
        case (funct3)
          3'b011: ctrl.mem_size = MEM_DOUBLE;
          3'b010: ctrl.mem_size = MEM_WORD;
          3'b100: begin
            ctrl.mem_size     = MEM_BYTE;
            ctrl.mem_unsigned = 1'b1;
          end
          default: ctrl.mem_size = MEM_DOUBLE;
        endcase
        ctrl.mem_read = (funct3 == 3'b011) || (funct3 == 3'b010) || (funct3 == 3'b100);
        writes        = ctrl.mem_read;
      end
      OPC_STORE: begin
        ctrl.op2 = imm_s;
        ctrl.imm = imm_s;
        case (funct3)
          3'b011:  ctrl.mem_size = MEM_DOUBLE;
          3'b010:  ctrl.mem_size = MEM_WORD;
          default: ctrl.mem_size = MEM_BYTE;
        endcase
        ctrl.mem_write = (funct3 == 3'b011) || (funct3 == 3'b010) || (funct3 == 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.imm    = imm_b;
        ctrl.alu_op = funct3[0] ? ALU_NE : ALU_EQ;
        ctrl.branch = (funct3 == 3'b000) || (funct3 == 3'b001);
      end
      OPC_JAL: begin
        // alu forms the target too, write-back takes pc+4
        ctrl.op1       = pc;
        ctrl.op2       = imm_j;
        ctrl.imm       = imm_j;
        ctrl.jump_kind = JUMP_JAL;
        ctrl.link      = 1'b1;
        writes         = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          ctrl.op2       = imm_i;
          ctrl.imm       = imm_i;
          ctrl.jump_kind = JUMP_JALR;
          ctrl.link      = 1'b1;
          writes         = 1'b1;
        end
      end
      default: writes = 1'b0;
    endcase
    ctrl.rd_wen = writes && (ctrl.rd_addr != 5'd0);
  end

endmodule

`default_nettype wire

// File: src/if_stage.sv
// fetch block holding the pc, the fetch handshake and next-pc selection
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module if_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      inst_valid,
  input  rv_core_pkg::decode_ctrl_t ctrl,
  input  logic                      take_branch,
  input  logic [`XLEN-1:0]          rs1_data,
  output logic [`XLEN-1:0]          fetch_pc,
  output logic                      inst_ready,
  output logic [`XLEN-1:0]          pc_plus4
);
  import rv_core_pkg::*;

  logic [`XLEN-1:0] next_pc;
  logic [`XLEN-1:0] jalr_target;

  assign pc_plus4    = fetch_pc + 4;
  assign jalr_target = rs1_data + ctrl.imm;

  always_comb begin
    case (ctrl.jump_kind)
      JUMP_JAL:  next_pc = fetch_pc + ctrl.imm;
      JUMP_JALR: next_pc = {jalr_target[`XLEN-1:1], 1'b0};
      default:   next_pc = take_branch ? fetch_pc + ctrl.imm : pc_plus4;
    endcase
  end

  // ready comes up one cycle after reset and stays up
  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc   <= `PC_START;
      inst_ready <= 1'b0;
    end else begin
      inst_ready <= 1'b1;
      if (inst_valid && inst_ready) begin
        fetch_pc <= next_pc;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/rv_core_pkg.sv
// control and commit records passed between the core blocks and out of the top level
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

  typedef enum logic [1:0] {
    JUMP_NONE = 2'd0,
    JUMP_JAL  = 2'd1,
    JUMP_JALR = 2'd2
  } jump_kind_e;

  typedef struct packed {
    rv_isa_pkg::alu_op_e   alu_op;
    logic [`XLEN-1:0]      op1;
    logic [`XLEN-1:0]      op2;
    logic [4:0]            rd_addr;
    logic                  rd_wen;
    logic                  mem_read;
    logic                  mem_write;
    rv_isa_pkg::mem_size_e mem_size;
    logic                  mem_unsigned;
    logic                  branch;
    jump_kind_e            jump_kind;
    logic [`XLEN-1:0]      imm;
    // rd gets pc+4
    logic                  link;
  } decode_ctrl_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [31:0]      inst;
    logic             wen;
    logic [4:0]       wdest;
    logic [`XLEN-1:0] wdata;
  } commit_t;

endpackage

`default_nettype wire

// File: src/rv_isa_pkg.sv
// RV64I encodings used by the decoder, ALU and memory stage; imported where decoding happens
`default_nettype none

package rv_isa_pkg;

  // major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  // ALU functions
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLL    = 4'd6,
    ALU_SRL    = 4'd7,
    ALU_PASS_B = 4'd8,
    // compare results land in bit 0
    ALU_EQ     = 4'd9,
    ALU_NE     = 4'd10
  } alu_op_e;

  // load/store access width
  typedef enum logic [1:0] {
    MEM_BYTE   = 2'd0,
    MEM_WORD   = 2'd2,
    MEM_DOUBLE = 2'd3
  } mem_size_e;

endpackage

`default_nettype wire

// File: src/rv_core_macros.svh
// core-wide constants, included by the core package and by modules that size their data paths
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// pc after reset
`define PC_START 64'h0000_0000_8000_0000

// integer data width
`define XLEN 64

// architectural integer registers
`define REG_COUNT 32

// 64-bit words in the internal data RAM
`define DMEM_WORDS 64

`endif
